/* bpf_defs.svh */
`ifndef BPF_DEFS_SVH
`define BPF_DEFS_SVH

// Memory geometry
`define BPF_CODE_AW   6
`define BPF_PKT_AW    8
`define BPF_SCRATCH_N 16

// Instruction class in opcode[2:0]
`define BPF_LD   3'h0
`define BPF_LDX  3'h1
`define BPF_ST   3'h2
`define BPF_STX  3'h3
`define BPF_ALU  3'h4
`define BPF_JMP  3'h5
`define BPF_RET  3'h6
`define BPF_MISC 3'h7

// Load size in opcode[4:3]
`define BPF_W 2'h0
`define BPF_H 2'h1
`define BPF_B 2'h2

// Addressing mode in opcode[7:5]
`define BPF_IMM 3'h0
`define BPF_ABS 3'h1
`define BPF_IND 3'h2
`define BPF_MEM 3'h3

// Operand source in opcode[3]
`define BPF_SRC_X 1'b1

// ALU operation in opcode[7:4]
`define BPF_ADD 4'h0
`define BPF_SUB 4'h1
`define BPF_OR  4'h4
`define BPF_AND 4'h5
`define BPF_LSH 4'h6
`define BPF_RSH 4'h7

// Jump operation in opcode[7:4]
`define BPF_JA   4'h0
`define BPF_JEQ  4'h1
`define BPF_JGT  4'h2
`define BPF_JGE  4'h3
`define BPF_JSET 4'h4

// Return value source in opcode[4:3]
`define BPF_RVAL_K 2'h0
`define BPF_RVAL_A 2'h2

// Misc operation in opcode[7:3]
`define BPF_TAX 5'h00
`define BPF_TXA 5'h10

`endif

/* bpf_pkg.sv */
`include "bpf_defs.svh"

package bpf_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`BPF_CODE_AW-1:0] code_addr_t;
    typedef logic [`BPF_PKT_AW-1:0] pkt_addr_t;

    // Classic BPF instruction layout
    typedef struct packed {
        logic [15:0] opcode;
        logic [7:0]  jt;
        logic [7:0]  jf;
        word_t       k;
    } instr_t;

    typedef struct packed {
        code_addr_t pc;
        logic       vld;
    } fetch_t;

    // PASS_B forwards the K or X operand for moves and immediate loads
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_LSH,
        ALU_RSH,
        ALU_PASS_A,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        LD_W,
        LD_H,
        LD_B
    } ld_size_e;

    typedef enum logic [2:0] {
        JMP_NONE,
        JMP_ALWAYS,
        JMP_EQ,
        JMP_GT,
        JMP_GE,
        JMP_SET
    } jmp_kind_e;

    typedef struct packed {
        logic       vld;
        code_addr_t pc;
        word_t      k;
        logic [7:0] jt;
        logic [7:0] jf;
        logic       dest_a;
        logic       dest_x;
        logic       src_x;
        logic       src_mem;
        logic       src_pkt;
        logic       pkt_ind;
        ld_size_e   ld_size;
        alu_op_e    alu_op;
        logic       is_store;
        logic       store_x;
        jmp_kind_e  jmp_kind;
        logic       is_ret;
        logic       ret_a;
    } ctrl_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        LOAD_WAIT
    } exec_state_e;

endpackage

/* bpf_code_mem.sv */
`timescale 1ns/1ps
`include "bpf_defs.svh"

module bpf_code_mem (
    input  logic                clk,
    input  logic                code_wr_en,
    input  bpf_pkg::code_addr_t code_wr_addr,
    input  bpf_pkg::instr_t     code_wr_data,
    input  bpf_pkg::fetch_t     fetch,
    output bpf_pkg::instr_t     instr
);
    import bpf_pkg::*;

    instr_t mem [2**`BPF_CODE_AW];

    // Host program load
    always_ff @(posedge clk) begin
        if (code_wr_en) begin
            mem[code_wr_addr] <= code_wr_data;
        end
    end

    // Read data holds while no fetch is issued, so a stall keeps it aligned
    always_ff @(posedge clk) begin
        if (fetch.vld) begin
            instr <= mem[fetch.pc];
        end
    end

endmodule

/* bpf_packet_mem.sv */
`timescale 1ns/1ps
`include "bpf_defs.svh"

module bpf_packet_mem (
    input  logic               clk,
    input  logic               pkt_wr_en,
    input  bpf_pkg::pkt_addr_t pkt_wr_addr,
    input  logic [7:0]         pkt_wr_data,
    input  bpf_pkg::pkt_addr_t pkt_len,
    input  logic               pkt_rd_en,
    input  bpf_pkg::pkt_addr_t pkt_rd_addr,
    input  bpf_pkg::ld_size_e  pkt_rd_size,
    output bpf_pkg::word_t     pkt_rd_data,
    output logic               oob
);
    import bpf_pkg::*;

    logic [7:0] mem [2**`BPF_PKT_AW];
    pkt_addr_t  addr1;
    pkt_addr_t  addr2;
    pkt_addr_t  addr3;
    logic [1:0] span;
    logic [`BPF_PKT_AW:0] last;

    assign addr1 = pkt_rd_addr + pkt_addr_t'(1);
    assign addr2 = pkt_rd_addr + pkt_addr_t'(2);
    assign addr3 = pkt_rd_addr + pkt_addr_t'(3);

    // Offset of the last byte touched by the load
    always_comb begin
        case (pkt_rd_size)
            LD_W:    span = 2'd3;
            LD_H:    span = 2'd1;
            default: span = 2'd0;
        endcase
    end

    // One extra bit so that a load running past the top of memory is caught
    assign last = {1'b0, pkt_rd_addr} + {{(`BPF_PKT_AW-1){1'b0}}, span};

    always_ff @(posedge clk) begin
        if (pkt_wr_en) begin
            mem[pkt_wr_addr] <= pkt_wr_data;
        end
    end

    // Network byte order with zero extension
    always_ff @(posedge clk) begin
        if (pkt_rd_en) begin
            case (pkt_rd_size)
                LD_W:    pkt_rd_data <= {mem[pkt_rd_addr], mem[addr1], mem[addr2], mem[addr3]};
                LD_H:    pkt_rd_data <= {16'h0000, mem[pkt_rd_addr], mem[addr1]};
                default: pkt_rd_data <= {24'h000000, mem[pkt_rd_addr]};
            endcase
            oob <= last >= {1'b0, pkt_len};
        end
    end

    // Host loading and the filter run must never overlap
    assert property (@(posedge clk) !(pkt_rd_en && pkt_wr_en))
        else $error("packet read during host write");

endmodule

/* bpf_fetch.sv */
`timescale 1ns/1ps

module bpf_fetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                run,
    input  logic                stall,
    input  logic                redirect,
    input  bpf_pkg::code_addr_t redirect_pc,
    output bpf_pkg::fetch_t     fetch,
    output bpf_pkg::fetch_t     fetch_q
);
    import bpf_pkg::*;

    code_addr_t pc;

    // The slot of a redirect cycle is wrong path, so no fetch there
    assign fetch.pc  = pc;
    assign fetch.vld = run && !stall && !redirect;

    always_ff @(posedge clk) begin
        if (reset || start) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (fetch.vld) begin
            pc <= pc + code_addr_t'(1);
        end
    end

    // Lines up with the code memory read data
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_q.vld <= 1'b0;
        end else if (redirect) begin
            fetch_q.vld <= 1'b0;
        end else if (!stall) begin
            fetch_q <= fetch;
        end
    end

endmodule

/* bpf_decode.sv */
`timescale 1ns/1ps
`include "bpf_defs.svh"

module bpf_decode (
    input  logic            clk,
    input  logic            reset,
    input  bpf_pkg::fetch_t fetch_q,
    input  bpf_pkg::instr_t instr,
    input  logic            stall,
    input  logic            redirect,
    output bpf_pkg::ctrl_t  ctrl
);
    import bpf_pkg::*;

    ctrl_t      dec;
    logic       bad;
    logic [2:0] cls;
    logic [1:0] size;
    logic [2:0] mode;
    logic [3:0] op;

    assign cls  = instr.opcode[2:0];
    assign size = instr.opcode[4:3];
    assign mode = instr.opcode[7:5];
    assign op   = instr.opcode[7:4];

    always_comb begin
        dec = '0;
        dec.alu_op = ALU_PASS_B;
        bad = instr.opcode[15:8] != '0;
        case (cls)
            `BPF_LD: begin
                dec.dest_a = 1'b1;
                case (size)
                    `BPF_W:  dec.ld_size = LD_W;
                    `BPF_H:  dec.ld_size = LD_H;
                    `BPF_B:  dec.ld_size = LD_B;
                    default: bad = 1'b1;
                endcase
                case (mode)
                    `BPF_IMM: dec.src_pkt = 1'b0;
                    `BPF_ABS: dec.src_pkt = 1'b1;
                    `BPF_IND: begin
                        dec.src_pkt = 1'b1;
                        dec.pkt_ind = 1'b1;
                    end
                    `BPF_MEM: dec.src_mem = 1'b1;
                    default:  bad = 1'b1;
                endcase
            end
            `BPF_LDX: begin
                dec.dest_x  = 1'b1;
                dec.src_mem = mode == `BPF_MEM;
                if (mode != `BPF_IMM && mode != `BPF_MEM) begin
                    bad = 1'b1;
                end
            end
            `BPF_ST: dec.is_store = 1'b1;
            `BPF_STX: begin
                dec.is_store = 1'b1;
                dec.store_x  = 1'b1;
            end
            `BPF_ALU: begin
                dec.dest_a = 1'b1;
                dec.src_x  = instr.opcode[3] == `BPF_SRC_X;
                case (op)
                    `BPF_ADD: dec.alu_op = ALU_ADD;
                    `BPF_SUB: dec.alu_op = ALU_SUB;
                    `BPF_AND: dec.alu_op = ALU_AND;
                    `BPF_OR:  dec.alu_op = ALU_OR;
                    `BPF_LSH: dec.alu_op = ALU_LSH;
                    `BPF_RSH: dec.alu_op = ALU_RSH;
                    default:  bad = 1'b1;
                endcase
            end
            `BPF_JMP: begin
                case (op)
                    `BPF_JA:   dec.jmp_kind = JMP_ALWAYS;
                    `BPF_JEQ:  dec.jmp_kind = JMP_EQ;
                    `BPF_JGT:  dec.jmp_kind = JMP_GT;
                    `BPF_JGE:  dec.jmp_kind = JMP_GE;
                    `BPF_JSET: dec.jmp_kind = JMP_SET;
                    default:   bad = 1'b1;
                endcase
                // Only the K forms are supported
                if (instr.opcode[3] == `BPF_SRC_X) begin
                    bad = 1'b1;
                end
            end
            `BPF_RET: begin
                dec.is_ret = 1'b1;
                dec.ret_a  = size == `BPF_RVAL_A;
                if (size != `BPF_RVAL_A && size != `BPF_RVAL_K) begin
                    bad = 1'b1;
                end
            end
            `BPF_MISC: begin
                case (instr.opcode[7:3])
                    `BPF_TAX: begin
                        dec.dest_x = 1'b1;
                        dec.alu_op = ALU_PASS_A;
                    end
                    `BPF_TXA: begin
                        dec.dest_a = 1'b1;
                        dec.src_x  = 1'b1;
                    end
                    default: bad = 1'b1;
                endcase
            end
            default: bad = 1'b1;
        endcase
        // Anything unsupported becomes RET 0 and rejects the packet
        if (bad) begin
            dec = '0;
            dec.is_ret = 1'b1;
        end else begin
            dec.k  = instr.k;
            dec.jt = instr.jt;
            dec.jf = instr.jf;
        end
        dec.vld = fetch_q.vld;
        dec.pc  = fetch_q.pc;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.vld <= 1'b0;
        end else if (redirect) begin
            ctrl.vld <= 1'b0;
        end else if (!stall) begin
            ctrl <= dec;
        end
    end

endmodule

/* bpf_execute.sv */
`timescale 1ns/1ps
`include "bpf_defs.svh"

module bpf_execute (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  bpf_pkg::ctrl_t      ctrl,
    output logic                pkt_rd_en,
    output bpf_pkg::pkt_addr_t  pkt_rd_addr,
    output bpf_pkg::ld_size_e   pkt_rd_size,
    input  bpf_pkg::word_t      pkt_rd_data,
    input  logic                oob,
    output logic                stall,
    output logic                redirect,
    output bpf_pkg::code_addr_t redirect_pc,
    output logic                run,
    output logic                acc,
    output logic                rej,
    output bpf_pkg::word_t      ret_value
);
    import bpf_pkg::*;

    exec_state_e state;
    word_t       a_reg;
    word_t       x_reg;
    word_t       scratch [`BPF_SCRATCH_N];
    logic [$clog2(`BPF_SCRATCH_N)-1:0] mem_idx;
    word_t       opb;
    word_t       alu_res;
    word_t       wb_val;
    word_t       ret_src;
    word_t       ld_addr;
    logic        ld_far;
    logic        ld_far_q;
    logic        load_bad;
    logic        issue;
    logic        taken;
    code_addr_t  jmp_off;

    assign run     = state != IDLE;
    assign issue   = (state == RUN) && ctrl.vld;
    assign mem_idx = ctrl.k[$clog2(`BPF_SCRATCH_N)-1:0];
    assign opb     = ctrl.src_x ? x_reg : ctrl.k;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_res = a_reg + opb;
            ALU_SUB:    alu_res = a_reg - opb;
            ALU_AND:    alu_res = a_reg & opb;
            ALU_OR:     alu_res = a_reg | opb;
            ALU_LSH:    alu_res = a_reg << opb;
            ALU_RSH:    alu_res = a_reg >> opb;
            ALU_PASS_A: alu_res = a_reg;
            default:    alu_res = opb;
        endcase
    end

    assign wb_val  = ctrl.src_mem ? scratch[mem_idx] : alu_res;
    assign ret_src = ctrl.ret_a ? a_reg : ctrl.k;

    // Branch condition against K only
    always_comb begin
        case (ctrl.jmp_kind)
            JMP_EQ:  taken = a_reg == ctrl.k;
            JMP_GT:  taken = a_reg > ctrl.k;
            JMP_GE:  taken = a_reg >= ctrl.k;
            JMP_SET: taken = (a_reg & ctrl.k) != '0;
            default: taken = 1'b1;
        endcase
    end

    assign jmp_off = (ctrl.jmp_kind == JMP_ALWAYS) ? code_addr_t'(ctrl.k) :
                     taken ? code_addr_t'(ctrl.jt) : code_addr_t'(ctrl.jf);
    assign redirect_pc = ctrl.pc + code_addr_t'(1) + jmp_off;

    // The upper address bits alone can put a packet load out of range
    assign ld_addr     = ctrl.k + (ctrl.pkt_ind ? x_reg : '0);
    assign ld_far      = ld_addr[31:`BPF_PKT_AW] != '0;
    assign pkt_rd_en   = issue && ctrl.src_pkt;
    assign pkt_rd_addr = ld_addr[`BPF_PKT_AW-1:0];
    assign pkt_rd_size = ctrl.ld_size;

    // Hold decode and fetch for the one load cycle
    assign stall    = pkt_rd_en;
    assign load_bad = (state == LOAD_WAIT) && (oob || ld_far_q);

    // Jumps and every end of run flush the younger instructions
    assign redirect = (issue && (ctrl.jmp_kind != JMP_NONE || ctrl.is_ret)) || load_bad;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            acc       <= 1'b0;
            rej       <= 1'b0;
            ret_value <= '0;
        end else begin
            acc <= 1'b0;
            rej <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (issue && ctrl.is_ret) begin
                        state     <= IDLE;
                        acc       <= ret_src != '0;
                        rej       <= ret_src == '0;
                        ret_value <= ret_src;
                    end else if (pkt_rd_en) begin
                        state <= LOAD_WAIT;
                    end
                end
                LOAD_WAIT: begin
                    state <= load_bad ? IDLE : RUN;
                    if (load_bad) begin
                        rej       <= 1'b1;
                        ret_value <= '0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Register file and scratch writes
    always_ff @(posedge clk) begin
        ld_far_q <= ld_far;
        if (issue && !ctrl.src_pkt) begin
            if (ctrl.dest_a) begin
                a_reg <= wb_val;
            end
            if (ctrl.dest_x) begin
                x_reg <= wb_val;
            end
            if (ctrl.is_store) begin
                scratch[mem_idx] <= ctrl.store_x ? x_reg : a_reg;
            end
        end
        if ((state == LOAD_WAIT) && !load_bad && ctrl.dest_a) begin
            a_reg <= pkt_rd_data;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
                     (state == LOAD_WAIT) |-> (ctrl.vld && ctrl.src_pkt))
        else $error("load left decode before its data returned");

    assert property (@(posedge clk) disable iff (reset) (state == IDLE) |-> !ctrl.vld)
        else $error("valid instruction while idle");

endmodule

/* bpf_filter_top.sv */
`timescale 1ns/1ps

module bpf_filter_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                code_wr_en,
    input  bpf_pkg::code_addr_t code_wr_addr,
    input  bpf_pkg::instr_t     code_wr_data,
    input  logic                pkt_wr_en,
    input  bpf_pkg::pkt_addr_t  pkt_wr_addr,
    input  logic [7:0]          pkt_wr_data,
    input  bpf_pkg::pkt_addr_t  pkt_len,
    input  logic                start,
    output logic                busy,
    output logic                acc,
    output logic                rej,
    output bpf_pkg::word_t      ret_value
);
    import bpf_pkg::*;

    fetch_t     fetch;
    fetch_t     fetch_q;
    instr_t     instr;
    ctrl_t      ctrl;
    logic       stall;
    logic       redirect;
    code_addr_t redirect_pc;
    logic       run;
    logic       start_ok;
    logic       pkt_rd_en;
    pkt_addr_t  pkt_rd_addr;
    ld_size_e   pkt_rd_size;
    word_t      pkt_rd_data;
    logic       oob;
    pkt_addr_t  pkt_len_q;

    // Host inputs only count between runs
    assign busy     = run;
    assign start_ok = start && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_len_q <= '0;
        end else if (!busy) begin
            pkt_len_q <= pkt_len;
        end
    end

    bpf_code_mem code_mem (
        .clk          (clk),
        .code_wr_en   (code_wr_en && !busy),
        .code_wr_addr (code_wr_addr),
        .code_wr_data (code_wr_data),
        .fetch        (fetch),
        .instr        (instr)
    );

    bpf_packet_mem packet_mem (
        .clk         (clk),
        .pkt_wr_en   (pkt_wr_en && !busy),
        .pkt_wr_addr (pkt_wr_addr),
        .pkt_wr_data (pkt_wr_data),
        .pkt_len     (pkt_len_q),
        .pkt_rd_en   (pkt_rd_en),
        .pkt_rd_addr (pkt_rd_addr),
        .pkt_rd_size (pkt_rd_size),
        .pkt_rd_data (pkt_rd_data),
        .oob         (oob)
    );

    bpf_fetch fetch_stage (
        .clk         (clk),
        .reset       (reset),
        .start       (start_ok),
        .run         (run),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch       (fetch),
        .fetch_q     (fetch_q)
    );

    bpf_decode decode_stage (
        .clk      (clk),
        .reset    (reset),
        .fetch_q  (fetch_q),
        .instr    (instr),
        .stall    (stall),
        .redirect (redirect),
        .ctrl     (ctrl)
    );

    bpf_execute exec_stage (
        .clk         (clk),
        .reset       (reset),
        .start       (start_ok),
        .ctrl        (ctrl),
        .pkt_rd_en   (pkt_rd_en),
        .pkt_rd_addr (pkt_rd_addr),
        .pkt_rd_size (pkt_rd_size),
        .pkt_rd_data (pkt_rd_data),
        .oob         (oob),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .run         (run),
        .acc         (acc),
        .rej         (rej),
        .ret_value   (ret_value)
    );

endmodule

/* tb_bpf_filter.sv */
`timescale 1ns/1ps

module tb_bpf_filter;
    import bpf_pkg::*;

    localparam int NUM_CASES = 13;
    localparam int PROG_LEN  = 16;
    localparam int PKT_BYTES = 64;
    localparam int CYCLE_LIMIT = NUM_CASES * 600;

    // Each table row holds the program, patch bytes with the first in the MSB, length and verdict
    typedef struct packed {
        logic [1:0]  prog;
        logic [7:0]  pbase;
        logic [2:0]  pcount;
        logic [31:0] pdata;
        logic [7:0]  len;
        logic        exp_acc;
        logic [31:0] exp_ret;
    } case_t;

    logic       clk;
    logic       reset;
    logic       code_wr_en;
    code_addr_t code_wr_addr;
    instr_t     code_wr_data;
    logic       pkt_wr_en;
    pkt_addr_t  pkt_wr_addr;
    logic [7:0] pkt_wr_data;
    pkt_addr_t  pkt_len;
    logic       start;
    logic       busy;
    logic       acc;
    logic       rej;
    word_t      ret_value;

    instr_t      prog_tab [4][PROG_LEN];
    case_t       case_tab [NUM_CASES];
    logic [15:0] lfsr_state;
    int          cycle_count;
    int          error_count;

    bpf_filter_top DUT (
        .clk          (clk),
        .reset        (reset),
        .code_wr_en   (code_wr_en),
        .code_wr_addr (code_wr_addr),
        .code_wr_data (code_wr_data),
        .pkt_wr_en    (pkt_wr_en),
        .pkt_wr_addr  (pkt_wr_addr),
        .pkt_wr_data  (pkt_wr_data),
        .pkt_len      (pkt_len),
        .start        (start),
        .busy         (busy),
        .acc          (acc),
        .rej          (rej),
        .ret_value    (ret_value)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: no verdict after %0d cycles", cycle_count);
            $display("Done: errors found");
            $fatal(1);
        end
    end

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic next_filler_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic instr_t encode_instr(logic [15:0] op, logic [7:0] jt, logic [7:0] jf,
                                            logic [31:0] k);
        instr_t r;
        r.opcode = op;
        r.jt = jt;
        r.jf = jf;
        r.k = k;
        return r;
    endfunction

    function automatic case_t make_case(logic [1:0] prog, logic [7:0] pbase, logic [2:0] pcount,
                                        logic [31:0] pdata, logic [7:0] len, logic exp_acc,
                                        logic [31:0] exp_ret);
        case_t c;
        c.prog = prog;
        c.pbase = pbase;
        c.pcount = pcount;
        c.pdata = pdata;
        c.len = len;
        c.exp_acc = exp_acc;
        c.exp_ret = exp_ret;
        return c;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic fill_programs();
        for (int p = 0; p < 4; p++) begin
            for (int i = 0; i < PROG_LEN; i++) begin
                prog_tab[p][i] = encode_instr(16'h06, 8'd0, 8'd0, 32'd0);
            end
        end
        // EtherType filter
        prog_tab[0][0] = encode_instr(16'h28, 8'd0, 8'd0, 32'd12);
        prog_tab[0][1] = encode_instr(16'h15, 8'd0, 8'd1, 32'h0800);
        prog_tab[0][2] = encode_instr(16'h06, 8'd0, 8'd0, 32'd65535);
        prog_tab[0][3] = encode_instr(16'h06, 8'd0, 8'd0, 32'd0);
        // Arithmetic through scratch and X
        prog_tab[1][0]  = encode_instr(16'h01, 8'd0, 8'd0, 32'd3);
        prog_tab[1][1]  = encode_instr(16'h50, 8'd0, 8'd0, 32'd20);
        prog_tab[1][2]  = encode_instr(16'h0c, 8'd0, 8'd0, 32'd0);
        prog_tab[1][3]  = encode_instr(16'h02, 8'd0, 8'd0, 32'd5);
        prog_tab[1][4]  = encode_instr(16'h00, 8'd0, 8'd0, 32'hdead);
        prog_tab[1][5]  = encode_instr(16'h60, 8'd0, 8'd0, 32'd5);
        prog_tab[1][6]  = encode_instr(16'h64, 8'd0, 8'd0, 32'd4);
        prog_tab[1][7]  = encode_instr(16'h14, 8'd0, 8'd0, 32'd7);
        prog_tab[1][8]  = encode_instr(16'h07, 8'd0, 8'd0, 32'd0);
        prog_tab[1][9]  = encode_instr(16'h00, 8'd0, 8'd0, 32'd0);
        prog_tab[1][10] = encode_instr(16'h87, 8'd0, 8'd0, 32'd0);
        prog_tab[1][11] = encode_instr(16'h16, 8'd0, 8'd0, 32'd0);
        // In the branch tree each block is followed by another block's LD IMM
        prog_tab[2][0]  = encode_instr(16'h30, 8'd0, 8'd0, 32'd14);
        prog_tab[2][1]  = encode_instr(16'h25, 8'd0, 8'd8, 32'h40);
        prog_tab[2][2]  = encode_instr(16'h45, 8'd5, 8'd0, 32'h01);
        prog_tab[2][3]  = encode_instr(16'h35, 8'd0, 8'd2, 32'h80);
        prog_tab[2][4]  = encode_instr(16'h00, 8'd0, 8'd0, 32'h44);
        prog_tab[2][5]  = encode_instr(16'h05, 8'd0, 8'd0, 32'd5);
        prog_tab[2][6]  = encode_instr(16'h00, 8'd0, 8'd0, 32'h33);
        prog_tab[2][7]  = encode_instr(16'h05, 8'd0, 8'd0, 32'd3);
        prog_tab[2][8]  = encode_instr(16'h00, 8'd0, 8'd0, 32'h22);
        prog_tab[2][9]  = encode_instr(16'h05, 8'd0, 8'd0, 32'd1);
        prog_tab[2][10] = encode_instr(16'h00, 8'd0, 8'd0, 32'h55);
        prog_tab[2][11] = encode_instr(16'h44, 8'd0, 8'd0, 32'h100);
        prog_tab[2][12] = encode_instr(16'h16, 8'd0, 8'd0, 32'd0);
        // Word load through ST, LDX MEM, STX and LD MEM
        prog_tab[3][0] = encode_instr(16'h20, 8'd0, 8'd0, 32'd16);
        prog_tab[3][1] = encode_instr(16'h02, 8'd0, 8'd0, 32'd2);
        prog_tab[3][2] = encode_instr(16'h00, 8'd0, 8'd0, 32'd0);
        prog_tab[3][3] = encode_instr(16'h61, 8'd0, 8'd0, 32'd2);
        prog_tab[3][4] = encode_instr(16'h03, 8'd0, 8'd0, 32'd7);
        prog_tab[3][5] = encode_instr(16'h60, 8'd0, 8'd0, 32'd7);
        prog_tab[3][6] = encode_instr(16'h74, 8'd0, 8'd0, 32'd8);
        prog_tab[3][7] = encode_instr(16'h54, 8'd0, 8'd0, 32'hffff);
        prog_tab[3][8] = encode_instr(16'h16, 8'd0, 8'd0, 32'd0);
    endtask

    task automatic fill_cases();
        case_tab[0]  = make_case(0, 12, 2, 32'h0800_0000, 60, 1'b1, 32'd65535);
        case_tab[1]  = make_case(0, 12, 2, 32'h86dd_0000, 60, 1'b0, 32'd0);
        // The EtherType matches but its second byte is past the end
        case_tab[2]  = make_case(0, 12, 2, 32'h0800_0000, 13, 1'b0, 32'd0);
        case_tab[3]  = make_case(1, 23, 1, 32'h2500_0000, 60, 1'b1,
                                 ((32'h25 + 32'd3) << 4) - 32'd7);
        case_tab[4]  = make_case(1, 23, 1, 32'hf000_0000, 60, 1'b1,
                                 ((32'hf0 + 32'd3) << 4) - 32'd7);
        case_tab[5]  = make_case(2, 14, 1, 32'h3100_0000, 60, 1'b1, 32'h55 | 32'h100);
        case_tab[6]  = make_case(2, 14, 1, 32'h4300_0000, 60, 1'b1, 32'h22 | 32'h100);
        case_tab[7]  = make_case(2, 14, 1, 32'h9000_0000, 60, 1'b1, 32'h44 | 32'h100);
        case_tab[8]  = make_case(2, 14, 1, 32'h6200_0000, 60, 1'b1, 32'h33 | 32'h100);
        case_tab[9]  = make_case(3, 16, 4, 32'h1234_5678, 20, 1'b1, (32'h12345678 >> 8) & 32'hffff);
        case_tab[10] = make_case(3, 16, 4, 32'ha1b2_c3d4, 60, 1'b1, (32'ha1b2c3d4 >> 8) & 32'hffff);
        case_tab[11] = make_case(3, 16, 4, 32'ha1b2_c3d4, 18, 1'b0, 32'd0);
        case_tab[12] = make_case(0, 12, 2, 32'h0800_0000, 60, 1'b1, 32'd65535);
    endtask

    task automatic load_program(input logic [1:0] prog);
        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge clk);
            code_wr_en = 1'b1;
            code_wr_addr = code_addr_t'(i);
            code_wr_data = prog_tab[prog][i];
        end
        @(negedge clk);
        code_wr_en = 1'b0;
    endtask

    task automatic load_packet(input case_t c);
        logic [7:0] img [PKT_BYTES];
        for (int i = 0; i < PKT_BYTES; i++) begin
            next_filler_byte(img[i]);
        end
        for (int i = 0; i < c.pcount; i++) begin
            img[c.pbase + i] = c.pdata[31 - 8 * i -: 8];
        end
        for (int i = 0; i < PKT_BYTES; i++) begin
            @(negedge clk);
            pkt_wr_en = 1'b1;
            pkt_wr_addr = pkt_addr_t'(i);
            pkt_wr_data = img[i];
        end
        @(negedge clk);
        pkt_wr_en = 1'b0;
    endtask

    task automatic run_case(input int idx);
        case_t c;
        string tag;
        c = case_tab[idx];
        tag = $sformatf("row %0d", idx);
        load_program(c.prog);
        load_packet(c);
        @(negedge clk);
        pkt_len = c.len;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value({tag, " busy after start"}, busy, 1);
        while (!(acc || rej)) begin
            @(negedge clk);
        end
        check_value({tag, " acc"}, acc, c.exp_acc);
        check_value({tag, " rej"}, rej, !c.exp_acc);
        check_value({tag, " ret_value"}, ret_value, c.exp_ret);
        check_value({tag, " busy at verdict"}, busy, 0);
    endtask

    initial begin
        reset = 1'b1;
        code_wr_en = 1'b0;
        code_wr_addr = '0;
        code_wr_data = '0;
        pkt_wr_en = 1'b0;
        pkt_wr_addr = '0;
        pkt_wr_data = '0;
        pkt_len = '0;
        start = 1'b0;
        lfsr_state = 16'd62;
        cycle_count = 0;
        error_count = 0;
        fill_programs();
        fill_cases();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("busy after reset", busy, 0);
        check_value("acc after reset", acc, 0);
        check_value("rej after reset", rej, 0);
        check_value("ret_value after reset", ret_value, 0);
        // Runs go back to back with no reset in between
        for (int r = 0; r < NUM_CASES; r++) begin
            run_case(r);
        end
        repeat (2) @(negedge clk);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
bpf_pkg.sv
bpf_code_mem.sv
bpf_packet_mem.sv
bpf_fetch.sv
bpf_decode.sv
bpf_execute.sv
bpf_filter_top.sv
tb_bpf_filter.sv
